//--- logic/exec_defines.svh
`ifndef EXEC_DEFINES_SVH
`define EXEC_DEFINES_SVH

// ============================================================
// datapath sizes
// ============================================================

`define EXEC_XLEN 32
`define EXEC_TAG_W 4

// one restoring step per quotient bit
`define EXEC_DIV_STEPS 32

// jump target register value out of reset
`define EXEC_RESET_PC 32'h0000_0000

// ============================================================
// machine csr addresses
// ============================================================

`define EXEC_CSR_MTVEC 12'h305
`define EXEC_CSR_MSCRATCH 12'h340
`define EXEC_CSR_MEPC 12'h341

`endif

//--- logic/exec_pkg.sv
`include "exec_defines.svh"

package exec_pkg;

	typedef logic [`EXEC_TAG_W-1:0] tag_t;
	typedef logic [`EXEC_XLEN-1:0] word_t;
	typedef logic [4:0] reg_index_t;

	// nine classes, so the field needs four bits
	typedef enum logic [3:0] {
		CLASS_ARITHMETIC,
		CLASS_SHIFT,
		CLASS_COMPARE,
		CLASS_JUMP,
		CLASS_BRANCH,
		CLASS_LOAD,
		CLASS_STORE,
		CLASS_COMPLEX,
		CLASS_INVALID
	} exec_class_t;

	typedef enum logic [3:0] {
		ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR,
		ALU_SLL, ALU_SRL, ALU_SRA,
		ALU_EQ, ALU_NE, ALU_LT, ALU_GE, ALU_LTU, ALU_GEU
	} alu_op_t;

	typedef enum logic [2:0] {
		SEL_ZERO, SEL_RS1, SEL_RS2, SEL_PC, SEL_IMM
	} operand_sel_t;

	typedef enum logic [3:0] {
		OP_MUL, OP_MULH, OP_MULHU,
		OP_DIV, OP_DIVU, OP_REM, OP_REMU,
		OP_CSRRW, OP_CSRRS,
		OP_ECALL, OP_MRET
	} complex_op_t;

	// immediate word, csr ops read only the low twelve bits as an index
	typedef union packed {
		word_t full;
		struct packed {
			logic [19:0] unused;
			logic [11:0] index;
		} csr;
	} imm_word_u;

	typedef struct packed {
		tag_t tag;
		word_t pc;
		imm_word_u imm;
		exec_class_t inst_class;
		alu_op_t alu_op;
		operand_sel_t operand1;
		operand_sel_t operand2;
		complex_op_t complex_op;
		reg_index_t rd_index;
		logic [1:0] mem_width;
		logic mem_signed;
	} decode_data_t;

	typedef struct packed {
		tag_t tag;
		word_t rd_value;
		reg_index_t rd_index;
		logic mem_read;
		logic mem_write;
		logic [1:0] mem_width;
		logic mem_signed;
		word_t mem_address;
		reg_index_t mem_rd_index;
	} execute_data_t;

	typedef struct packed {
		logic [11:0] index;
		logic write_enable;
		word_t write_data;
	} csr_req_t;

endpackage

//--- logic/exec_alu.sv
`timescale 1ns/1ps

`include "exec_defines.svh"

module exec_alu (
	input exec_pkg::alu_op_t i_op,
	input logic [`EXEC_XLEN-1:0] i_op1,
	input logic [`EXEC_XLEN-1:0] i_op2,
	output logic [`EXEC_XLEN-1:0] o_result,
	output logic [`EXEC_XLEN-1:0] o_shift_result,
	output logic [`EXEC_XLEN-1:0] o_signed_sum_result,
	output logic o_compare_result
);
	import exec_pkg::*;

	localparam int SHAMT_W = $clog2(`EXEC_XLEN);

	logic [SHAMT_W-1:0] shift_amount;
	logic signed_less;
	logic unsigned_less;

	assign shift_amount = i_op2[SHAMT_W-1:0];
	assign signed_less = $signed(i_op1) < $signed(i_op2);
	assign unsigned_less = i_op1 < i_op2;

	// address adder, also feeds jalr targets
	assign o_signed_sum_result = i_op1 + i_op2;

	always_comb begin
		case (i_op)
			ALU_SUB: o_result = i_op1 - i_op2;
			ALU_AND: o_result = i_op1 & i_op2;
			ALU_OR: o_result = i_op1 | i_op2;
			ALU_XOR: o_result = i_op1 ^ i_op2;
			default: o_result = o_signed_sum_result;
		endcase
	end

	always_comb begin
		case (i_op)
			ALU_SRL: o_shift_result = i_op1 >> shift_amount;
			// sign fill from bit 31
			ALU_SRA: o_shift_result = $signed(i_op1) >>> shift_amount;
			default: o_shift_result = i_op1 << shift_amount;
		endcase
	end

	always_comb begin
		case (i_op)
			ALU_EQ: o_compare_result = (i_op1 == i_op2);
			ALU_NE: o_compare_result = (i_op1 != i_op2);
			ALU_LT: o_compare_result = signed_less;
			ALU_GE: o_compare_result = !signed_less;
			ALU_LTU: o_compare_result = unsigned_less;
			ALU_GEU: o_compare_result = !unsigned_less;
			default: o_compare_result = 1'b0;
		endcase
	end

endmodule

//--- logic/exec_multiply.sv
`timescale 1ns/1ps

`include "exec_defines.svh"

module exec_multiply (
	input logic i_clock,
	input logic i_reset,
	input logic i_valid,
	input logic i_signed_a,
	input logic i_signed_b,
	input logic [`EXEC_XLEN-1:0] i_op1,
	input logic [`EXEC_XLEN-1:0] i_op2,
	output logic o_valid,
	output logic [2*`EXEC_XLEN-1:0] o_product
);

	// one extra bit lets a single signed multiplier cover both forms
	logic signed [`EXEC_XLEN:0] operand_a;
	logic signed [`EXEC_XLEN:0] operand_b;
	logic signed [2*`EXEC_XLEN-1:0] product;
	logic stage1_valid;

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			stage1_valid <= 1'b0;
			o_valid <= 1'b0;
		end else begin
			stage1_valid <= i_valid;
			o_valid <= stage1_valid;
		end
	end

	// stage 1 captures operands, stage 2 the low 64 product bits
	always_ff @(posedge i_clock) begin
		if (i_valid) begin
			operand_a <= {i_signed_a & i_op1[`EXEC_XLEN-1], i_op1};
			operand_b <= {i_signed_b & i_op2[`EXEC_XLEN-1], i_op2};
		end
		if (stage1_valid) begin
			product <= operand_a * operand_b;
		end
	end

	assign o_product = product;

endmodule

//--- logic/exec_divide.sv
`timescale 1ns/1ps

`include "exec_defines.svh"

module exec_divide (
	input logic i_clock,
	input logic i_reset,
	input logic i_start,
	input logic i_hold,
	input logic i_signed,
	input logic [`EXEC_XLEN-1:0] i_numerator,
	input logic [`EXEC_XLEN-1:0] i_denominator,
	output logic o_done,
	output logic [`EXEC_XLEN-1:0] o_quotient,
	output logic [`EXEC_XLEN-1:0] o_remainder
);

	localparam int COUNT_W = $clog2(`EXEC_DIV_STEPS + 1);

	logic running;
	logic [COUNT_W-1:0] steps_left;
	logic num_negative;
	logic den_negative;
	logic [`EXEC_XLEN-1:0] num_abs;
	logic [`EXEC_XLEN-1:0] den_abs;

	// datapath registers
	logic [`EXEC_XLEN-1:0] numerator;
	logic [`EXEC_XLEN-1:0] divisor;
	logic [`EXEC_XLEN-1:0] quotient;
	logic [`EXEC_XLEN-1:0] remainder;
	logic negate_quotient;
	logic negate_remainder;
	logic divide_by_zero;

	logic [`EXEC_XLEN:0] shifted;
	logic [`EXEC_XLEN+1:0] trial;

	assign num_negative = i_signed && i_numerator[`EXEC_XLEN-1];
	assign den_negative = i_signed && i_denominator[`EXEC_XLEN-1];
	assign num_abs = num_negative ? -i_numerator : i_numerator;
	assign den_abs = den_negative ? -i_denominator : i_denominator;

	// quotient register doubles as the numerator shift register
	assign shifted = {remainder, quotient[`EXEC_XLEN-1]};
	assign trial = {1'b0, shifted} - {2'b00, divisor};

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			running <= 1'b0;
			o_done <= 1'b0;
			steps_left <= '0;
		end else if (i_start) begin
			running <= 1'b1;
			o_done <= 1'b0;
			steps_left <= COUNT_W'(`EXEC_DIV_STEPS);
		end else if (running && !i_hold) begin
			steps_left <= steps_left - 1'b1;
			if (steps_left == COUNT_W'(1)) begin
				running <= 1'b0;
				o_done <= 1'b1;
			end
		end
	end

	always_ff @(posedge i_clock) begin
		if (i_start) begin
			numerator <= i_numerator;
			divisor <= den_abs;
			quotient <= num_abs;
			remainder <= '0;
			negate_quotient <= num_negative ^ den_negative;
			negate_remainder <= num_negative;
			divide_by_zero <= (i_denominator == '0);
		end else if (running && !i_hold) begin
			// borrow out of the trial subtract means restore
			if (trial[`EXEC_XLEN+1]) begin
				remainder <= shifted[`EXEC_XLEN-1:0];
				quotient <= {quotient[`EXEC_XLEN-2:0], 1'b0};
			end else begin
				remainder <= trial[`EXEC_XLEN-1:0];
				quotient <= {quotient[`EXEC_XLEN-2:0], 1'b1};
			end
		end
	end

	// min / -1 already yields min with remainder 0 through the unsigned core
	assign o_quotient = divide_by_zero ? '1 : (negate_quotient ? -quotient : quotient);
	assign o_remainder = divide_by_zero ? numerator : (negate_remainder ? -remainder : remainder);

	// the stage must wait for o_done before issuing the next division
	a_no_restart: assert property (@(posedge i_clock) disable iff (i_reset)
		i_start |-> !running);

endmodule

//--- logic/exec_stage.sv
`timescale 1ns/1ps

`include "exec_defines.svh"

module exec_stage (
	input logic i_clock,
	input logic i_reset,
	input exec_pkg::decode_data_t i_data,
	input logic [`EXEC_XLEN-1:0] i_rs1,
	input logic [`EXEC_XLEN-1:0] i_rs2,
	input logic i_memory_busy,
	input logic [`EXEC_XLEN-1:0] i_csr_rdata,
	input logic [`EXEC_XLEN-1:0] i_epc,
	input logic [`EXEC_XLEN-1:0] i_mtvec,
	output logic o_busy,
	output exec_pkg::execute_data_t o_data,
	output exec_pkg::csr_req_t o_csr_req,
	output logic o_jump,
	output logic [`EXEC_XLEN-1:0] o_jump_pc,
	output logic o_ecall,
	output logic o_fault
);
	import exec_pkg::*;

	function automatic logic [`EXEC_XLEN-1:0] select_operand(
		input operand_sel_t sel,
		input logic [`EXEC_XLEN-1:0] rs1,
		input logic [`EXEC_XLEN-1:0] rs2,
		input logic [`EXEC_XLEN-1:0] pc,
		input logic [`EXEC_XLEN-1:0] imm
	);
		case (sel)
			SEL_ZERO: return '0;
			SEL_RS1: return rs1;
			SEL_RS2: return rs2;
			SEL_PC: return pc;
			SEL_IMM: return imm;
			default: return '0;
		endcase
	endfunction

	logic pending;
	logic run;
	logic is_complex;
	logic is_load;
	logic [1:0] cycle;
	logic [`EXEC_XLEN-1:0] operand1;
	logic [`EXEC_XLEN-1:0] operand2;
	logic [`EXEC_XLEN-1:0] pc_plus_4;
	logic [`EXEC_XLEN-1:0] branch_target;

	logic [`EXEC_XLEN-1:0] alu_result;
	logic [`EXEC_XLEN-1:0] alu_shift_result;
	logic [`EXEC_XLEN-1:0] alu_signed_sum_result;
	logic alu_compare_result;

	logic is_mul;
	logic is_div;
	logic mul_valid;
	logic [2*`EXEC_XLEN-1:0] product;
	logic div_done;
	logic [`EXEC_XLEN-1:0] quotient;
	logic [`EXEC_XLEN-1:0] remainder;

	// what the current instruction would retire with this cycle
	logic complete;
	logic [`EXEC_XLEN-1:0] next_rd_value;
	logic take_jump;
	logic [`EXEC_XLEN-1:0] next_jump_pc;
	logic raise_ecall;
	logic raise_fault;
	logic csr_write;

	assign pending = (i_data.tag != o_data.tag);
	assign run = pending && !i_memory_busy;
	assign is_complex = (i_data.inst_class == CLASS_COMPLEX);
	assign is_load = (i_data.inst_class == CLASS_LOAD);
	assign o_busy = i_memory_busy || (pending && is_complex);

	assign operand1 = select_operand(i_data.operand1, i_rs1, i_rs2, i_data.pc, i_data.imm.full);
	assign operand2 = select_operand(i_data.operand2, i_rs1, i_rs2, i_data.pc, i_data.imm.full);
	assign pc_plus_4 = i_data.pc + 4;
	assign branch_target = i_data.pc + i_data.imm.full;

	// ============================================================
	// functional units
	// ============================================================

	exec_alu alu_i (
		.i_op(i_data.alu_op),
		.i_op1(operand1),
		.i_op2(operand2),
		.o_result(alu_result),
		.o_shift_result(alu_shift_result),
		.o_signed_sum_result(alu_signed_sum_result),
		.o_compare_result(alu_compare_result)
	);

	assign is_mul = is_complex && (i_data.complex_op inside {OP_MUL, OP_MULH, OP_MULHU});
	assign is_div = is_complex && (i_data.complex_op inside {OP_DIV, OP_DIVU, OP_REM, OP_REMU});

	// operands re-issued every running cycle, a stall cannot lose the product
	exec_multiply multiply_i (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_valid(run && is_mul),
		.i_signed_a(i_data.complex_op == OP_MULH),
		.i_signed_b(i_data.complex_op == OP_MULH),
		.i_op1(i_rs1),
		.i_op2(i_rs2),
		.o_valid(mul_valid),
		.o_product(product)
	);

	exec_divide divide_i (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_start(run && is_div && (cycle == 2'd0)),
		.i_hold(i_memory_busy),
		.i_signed(i_data.complex_op inside {OP_DIV, OP_REM}),
		.i_numerator(i_rs1),
		.i_denominator(i_rs2),
		.o_done(div_done),
		.o_quotient(quotient),
		.o_remainder(remainder)
	);

	// ============================================================
	// class dispatch
	// ============================================================

	always_comb begin
		complete = 1'b1;
		next_rd_value = '0;
		take_jump = 1'b0;
		next_jump_pc = pc_plus_4;
		raise_ecall = 1'b0;
		raise_fault = 1'b0;
		csr_write = 1'b0;
		case (i_data.inst_class)
			CLASS_ARITHMETIC: next_rd_value = alu_result;
			CLASS_SHIFT: next_rd_value = alu_shift_result;
			CLASS_COMPARE: next_rd_value = {{(`EXEC_XLEN-1){1'b0}}, alu_compare_result};
			CLASS_JUMP: begin
				next_rd_value = pc_plus_4;
				take_jump = 1'b1;
				next_jump_pc = {alu_signed_sum_result[`EXEC_XLEN-1:1], 1'b0};
			end
			CLASS_BRANCH: begin
				take_jump = 1'b1;
				next_jump_pc = alu_compare_result ? branch_target : pc_plus_4;
			end
			CLASS_LOAD: next_rd_value = '0;
			// store data rides in the rd value
			CLASS_STORE: next_rd_value = i_rs2;
			CLASS_COMPLEX: begin
				case (i_data.complex_op)
					OP_MUL: begin
						complete = mul_valid && (cycle >= 2'd2);
						next_rd_value = product[`EXEC_XLEN-1:0];
					end
					OP_MULH, OP_MULHU: begin
						complete = mul_valid && (cycle >= 2'd2);
						next_rd_value = product[2*`EXEC_XLEN-1:`EXEC_XLEN];
					end
					OP_DIV, OP_DIVU: begin
						complete = div_done && (cycle != 2'd0);
						next_rd_value = quotient;
					end
					OP_REM, OP_REMU: begin
						complete = div_done && (cycle != 2'd0);
						next_rd_value = remainder;
					end
					OP_CSRRW, OP_CSRRS: begin
						next_rd_value = i_csr_rdata;
						csr_write = 1'b1;
					end
					OP_ECALL: begin
						take_jump = 1'b1;
						next_jump_pc = i_mtvec;
						raise_ecall = 1'b1;
					end
					OP_MRET: begin
						take_jump = 1'b1;
						next_jump_pc = i_epc;
					end
					default: begin
						complete = 1'b0;
						raise_fault = 1'b1;
					end
				endcase
			end
			default: begin
				complete = 1'b0;
				raise_fault = 1'b1;
			end
		endcase
	end

	// write lands on the completing edge
	always_comb begin
		o_csr_req.index = i_data.imm.csr.index;
		o_csr_req.write_enable = run && csr_write;
		o_csr_req.write_data = (i_data.complex_op == OP_CSRRS) ? (i_csr_rdata | i_rs1) : i_rs1;
	end

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			o_data <= '0;
			cycle <= 2'd0;
			o_jump <= 1'b0;
			o_jump_pc <= `EXEC_RESET_PC;
			o_ecall <= 1'b0;
			o_fault <= 1'b0;
		end else begin
			o_jump <= 1'b0;
			o_ecall <= 1'b0;
			if (run) begin
				if (raise_fault) begin
					o_fault <= 1'b1;
				end
				if (complete) begin
					cycle <= 2'd0;
					o_data.tag <= i_data.tag;
					o_data.rd_value <= next_rd_value;
					// loads write back from the memory stage
					o_data.rd_index <= is_load ? '0 : i_data.rd_index;
					o_data.mem_read <= is_load;
					o_data.mem_write <= (i_data.inst_class == CLASS_STORE);
					o_data.mem_width <= i_data.mem_width;
					o_data.mem_signed <= i_data.mem_signed;
					o_data.mem_address <= alu_signed_sum_result;
					o_data.mem_rd_index <= i_data.rd_index;
					o_jump <= take_jump;
					o_ecall <= raise_ecall;
					if (take_jump) begin
						o_jump_pc <= next_jump_pc;
					end
				end else if (cycle != 2'd3) begin
					cycle <= cycle + 2'd1;
				end
			end
		end
	end

	// a faulted stage never retires, so it can never redirect
	a_jump_not_fault: assert property (@(posedge i_clock) disable iff (i_reset)
		!(o_jump && o_fault));

	a_tag_needs_memory: assert property (@(posedge i_clock) disable iff (i_reset)
		$changed(o_data.tag) |-> !$past(i_memory_busy));

endmodule

//--- logic/exec_csr_file.sv
`timescale 1ns/1ps

`include "exec_defines.svh"

module exec_csr_file (
	input logic i_clock,
	input logic i_reset,
	input exec_pkg::csr_req_t i_req,
	output logic [`EXEC_XLEN-1:0] o_rdata,
	output logic [`EXEC_XLEN-1:0] o_epc,
	output logic [`EXEC_XLEN-1:0] o_mtvec
);

	logic [`EXEC_XLEN-1:0] mscratch;
	logic [`EXEC_XLEN-1:0] mtvec;
	logic [`EXEC_XLEN-1:0] mepc;

	// unimplemented indices read as zero
	always_comb begin
		case (i_req.index)
			`EXEC_CSR_MSCRATCH: o_rdata = mscratch;
			`EXEC_CSR_MTVEC: o_rdata = mtvec;
			`EXEC_CSR_MEPC: o_rdata = mepc;
			default: o_rdata = '0;
		endcase
	end

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			mscratch <= '0;
			mtvec <= '0;
			mepc <= '0;
		end else if (i_req.write_enable) begin
			case (i_req.index)
				`EXEC_CSR_MSCRATCH: mscratch <= i_req.write_data;
				`EXEC_CSR_MTVEC: mtvec <= i_req.write_data;
				`EXEC_CSR_MEPC: mepc <= i_req.write_data;
				default: ;
			endcase
		end
	end

	assign o_epc = mepc;
	assign o_mtvec = mtvec;

endmodule

//--- logic/exec_top.sv
`timescale 1ns/1ps

`include "exec_defines.svh"

module exec_top (
	input logic i_clock,
	input logic i_reset,
	input exec_pkg::decode_data_t i_data,
	input logic [`EXEC_XLEN-1:0] i_rs1,
	input logic [`EXEC_XLEN-1:0] i_rs2,
	input logic i_memory_busy,
	output logic o_busy,
	output exec_pkg::execute_data_t o_data,
	output logic o_jump,
	output logic [`EXEC_XLEN-1:0] o_jump_pc,
	output logic o_ecall,
	output logic o_fault
);

	exec_pkg::csr_req_t csr_req;
	logic [`EXEC_XLEN-1:0] csr_rdata;
	logic [`EXEC_XLEN-1:0] epc;
	logic [`EXEC_XLEN-1:0] mtvec;

	exec_stage exec_stage_i (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_data(i_data),
		.i_rs1(i_rs1),
		.i_rs2(i_rs2),
		.i_memory_busy(i_memory_busy),
		.i_csr_rdata(csr_rdata),
		.i_epc(epc),
		.i_mtvec(mtvec),
		.o_busy(o_busy),
		.o_data(o_data),
		.o_csr_req(csr_req),
		.o_jump(o_jump),
		.o_jump_pc(o_jump_pc),
		.o_ecall(o_ecall),
		.o_fault(o_fault)
	);

	exec_csr_file exec_csr_file_i (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_req(csr_req),
		.o_rdata(csr_rdata),
		.o_epc(epc),
		.o_mtvec(mtvec)
	);

endmodule

//--- verification/exec_checker.sv
`timescale 1ns/1ps

`include "exec_defines.svh"

module exec_checker (
	input logic i_clock,
	input logic i_reset,
	input exec_pkg::decode_data_t i_instr,
	input exec_pkg::execute_data_t i_result,
	input logic i_memory_busy,
	input logic i_busy,
	input logic i_jump,
	input logic [`EXEC_XLEN-1:0] i_jump_pc,
	input logic i_ecall,
	input logic i_fault,
	input logic [`EXEC_XLEN-1:0] i_expect_rd,
	input logic i_expect_jump,
	input logic [`EXEC_XLEN-1:0] i_expect_jump_pc,
	input logic [`EXEC_XLEN-1:0] i_expect_address,
	input int i_index,
	output int o_error_count,
	output int o_result_count
);
	import exec_pkg::*;

	tag_t last_tag = '0;
	logic fault_seen = 1'b0;
	int error_count = 0;
	int result_count = 0;

	assign o_error_count = error_count;
	assign o_result_count = result_count;

	function automatic string test_name(input decode_data_t instr, input int index);
		exec_class_t inst_class;
		alu_op_t alu_op;
		complex_op_t op;
		inst_class = instr.inst_class;
		alu_op = instr.alu_op;
		op = instr.complex_op;
		if (inst_class == CLASS_COMPLEX) begin
			return $sformatf("vector %0d %s", index, op.name());
		end
		return $sformatf("vector %0d %s %s", index, inst_class.name(), alu_op.name());
	endfunction

	task automatic check_value(input string name, input string field,
		input logic [31:0] expected, input logic [31:0] actual);
		if (actual !== expected) begin
			error_count++;
			$display("[FAIL] %s %s expected %h actual %h", name, field, expected, actual);
		end
	endtask

	// ============================================================
	// one completed instruction
	// ============================================================

	task automatic compare_result();
		string name;
		logic is_load;
		logic is_store;
		logic is_ecall;
		name = test_name(i_instr, i_index);
		is_load = (i_instr.inst_class == CLASS_LOAD);
		is_store = (i_instr.inst_class == CLASS_STORE);
		is_ecall = (i_instr.inst_class == CLASS_COMPLEX) && (i_instr.complex_op == OP_ECALL);
		result_count++;
		check_value(name, "tag", 32'(i_instr.tag), 32'(i_result.tag));
		check_value(name, "rd_value", i_expect_rd, i_result.rd_value);
		check_value(name, "jump", 32'(i_expect_jump), 32'(i_jump));
		// target only means something when a jump is taken
		if (i_expect_jump) begin
			check_value(name, "jump_pc", i_expect_jump_pc, i_jump_pc);
		end
		check_value(name, "ecall", 32'(is_ecall), 32'(i_ecall));
		check_value(name, "mem_read", 32'(is_load), 32'(i_result.mem_read));
		check_value(name, "mem_write", 32'(is_store), 32'(i_result.mem_write));
		if (is_load || is_store) begin
			check_value(name, "mem_address", i_expect_address, i_result.mem_address);
			check_value(name, "mem_width", 32'(i_instr.mem_width), 32'(i_result.mem_width));
			check_value(name, "mem_signed", 32'(i_instr.mem_signed),
				32'(i_result.mem_signed));
			check_value(name, "mem_rd_index", 32'(i_instr.rd_index),
				32'(i_result.mem_rd_index));
		end else begin
			check_value(name, "rd_index", 32'(i_instr.rd_index), 32'(i_result.rd_index));
		end
		check_value(name, "fault", 32'h0, 32'(i_fault));
	endtask

	// results land on the rising edge, look at them half a cycle later
	always @(negedge i_clock) begin
		if (i_reset) begin
			last_tag = '0;
			fault_seen = 1'b0;
		end else begin
			if (i_result.tag != last_tag) begin
				last_tag = i_result.tag;
				compare_result();
			end
			if (fault_seen && !i_fault) begin
				error_count++;
				$display("o_fault dropped after it had been raised, without a reset");
			end
			fault_seen = fault_seen || i_fault;
		end
	end

	// busy is combinational, inputs only move on the falling edge
	always @(posedge i_clock) begin
		logic expect_busy;
		if (!i_reset) begin
			expect_busy = i_memory_busy
				|| ((i_instr.tag != i_result.tag) && (i_instr.inst_class == CLASS_COMPLEX));
			check_value(test_name(i_instr, i_index), "busy", 32'(expect_busy), 32'(i_busy));
		end
	end

endmodule

//--- verification/tb_exec.sv
`timescale 1ns/1ps

`include "exec_defines.svh"

module tb_exec;
	import exec_pkg::*;

	// one line of the vector file
	typedef struct packed {
		logic [3:0] inst_class;
		logic [3:0] alu_op;
		logic [2:0] operand1;
		logic [2:0] operand2;
		logic [3:0] complex_op;
		logic [`EXEC_XLEN-1:0] pc;
		logic [`EXEC_XLEN-1:0] imm;
		logic [`EXEC_XLEN-1:0] rs1;
		logic [`EXEC_XLEN-1:0] rs2;
		logic [`EXEC_XLEN-1:0] expect_rd;
		logic expect_jump;
		logic [`EXEC_XLEN-1:0] expect_jump_pc;
		logic [`EXEC_XLEN-1:0] expect_address;
	} vector_t;

	logic i_clock = 1'b0;
	logic i_reset = 1'b1;
	decode_data_t i_data = '0;
	logic [`EXEC_XLEN-1:0] i_rs1 = '0;
	logic [`EXEC_XLEN-1:0] i_rs2 = '0;
	logic i_memory_busy = 1'b0;
	logic o_busy;
	execute_data_t o_data;
	logic o_jump;
	logic [`EXEC_XLEN-1:0] o_jump_pc;
	logic o_ecall;
	logic o_fault;

	logic [`EXEC_XLEN-1:0] expect_rd = '0;
	logic expect_jump = 1'b0;
	logic [`EXEC_XLEN-1:0] expect_jump_pc = '0;
	logic [`EXEC_XLEN-1:0] expect_address = '0;
	int vector_index = 0;

	vector_t vectors[$];
	integer seed = 35;
	int tb_errors = 0;
	int expected_results = 0;
	int cycle_count = 0;
	int cycle_limit = 0;
	logic saw_invalid = 1'b0;
	int checker_errors;
	int checker_results;

	exec_top exec_top_i (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_data(i_data),
		.i_rs1(i_rs1),
		.i_rs2(i_rs2),
		.i_memory_busy(i_memory_busy),
		.o_busy(o_busy),
		.o_data(o_data),
		.o_jump(o_jump),
		.o_jump_pc(o_jump_pc),
		.o_ecall(o_ecall),
		.o_fault(o_fault)
	);

	exec_checker exec_checker_i (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_instr(i_data),
		.i_result(o_data),
		.i_memory_busy(i_memory_busy),
		.i_busy(o_busy),
		.i_jump(o_jump),
		.i_jump_pc(o_jump_pc),
		.i_ecall(o_ecall),
		.i_fault(o_fault),
		.i_expect_rd(expect_rd),
		.i_expect_jump(expect_jump),
		.i_expect_jump_pc(expect_jump_pc),
		.i_expect_address(expect_address),
		.i_index(vector_index),
		.o_error_count(checker_errors),
		.o_result_count(checker_results)
	);

	always #4 i_clock = ~i_clock;

	// random memory stalls, roughly one cycle in eight
	always @(negedge i_clock) begin
		if (i_reset) begin
			i_memory_busy = 1'b0;
		end else begin
			i_memory_busy = (($random(seed) & 7) == 0);
		end
	end

	always @(posedge i_clock) begin
		cycle_count <= cycle_count + 1;
		if (cycle_limit != 0 && cycle_count >= cycle_limit) begin
			$display("timeout: no progress within %0d cycles", cycle_limit);
			$display("Simulation finished: FAIL");
			$finish;
		end
	end

	// ============================================================
	// vector file
	// ============================================================

	task automatic read_vectors();
		int fd;
		int count;
		string line;
		logic [31:0] field [13];
		vector_t v;
		fd = $fopen("verification/exec_vectors.txt", "r");
		if (fd == 0) begin
			tb_errors++;
			$display("cannot open verification/exec_vectors.txt");
			return;
		end
		while (!$feof(fd)) begin
			line = "";
			void'($fgets(line, fd));
			if (line.len() < 2 || line.getc(0) == "#") begin
				continue;
			end
			count = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h",
				field[0], field[1], field[2], field[3], field[4], field[5], field[6],
				field[7], field[8], field[9], field[10], field[11], field[12]);
			if (count != 13) begin
				tb_errors++;
				$display("vector line could not be parsed: %s", line);
			end else begin
				v.inst_class = field[0][3:0];
				v.alu_op = field[1][3:0];
				v.operand1 = field[2][2:0];
				v.operand2 = field[3][2:0];
				v.complex_op = field[4][3:0];
				v.pc = field[5];
				v.imm = field[6];
				v.rs1 = field[7];
				v.rs2 = field[8];
				v.expect_rd = field[9];
				v.expect_jump = field[10][0];
				v.expect_jump_pc = field[11];
				v.expect_address = field[12];
				vectors.push_back(v);
			end
		end
		$fclose(fd);
	endtask

	// ============================================================
	// stimulus
	// ============================================================

	task automatic run_vector(input vector_t v, input int index);
		tag_t tag;
		int waited;
		// tags cycle through 1..15, never the reset value
		tag = tag_t'((index % 15) + 1);
		vector_index = index;
		i_data.tag = tag;
		i_data.pc = v.pc;
		i_data.imm.full = v.imm;
		i_data.inst_class = exec_class_t'(v.inst_class);
		i_data.alu_op = alu_op_t'(v.alu_op);
		i_data.operand1 = operand_sel_t'(v.operand1);
		i_data.operand2 = operand_sel_t'(v.operand2);
		i_data.complex_op = complex_op_t'(v.complex_op);
		i_data.rd_index = 5'(index + 1);
		// memory attributes vary per vector so they are seen to pass through
		i_data.mem_width = 2'(index);
		i_data.mem_signed = index[0];
		i_rs1 = v.rs1;
		i_rs2 = v.rs2;
		expect_rd = v.expect_rd;
		expect_jump = v.expect_jump;
		expect_jump_pc = v.expect_jump_pc;
		expect_address = v.expect_address;
		if (v.inst_class == CLASS_INVALID) begin
			saw_invalid = 1'b1;
			waited = 0;
			while (!o_fault && waited < 20) begin
				@(negedge i_clock);
				waited++;
			end
			if (!o_fault) begin
				tb_errors++;
				$display("vector %0d: o_fault did not rise for the invalid class", index);
			end
			// an invalid instruction never retires, so take it back
			i_data.tag = o_data.tag;
		end else begin
			expected_results++;
			while (o_data.tag != tag) begin
				@(negedge i_clock);
			end
		end
	endtask

	initial begin
		read_vectors();
		cycle_limit = vectors.size() * (`EXEC_DIV_STEPS + 12) + 50;
		repeat (10) @(posedge i_clock);
		@(negedge i_clock);
		i_reset = 1'b0;
		foreach (vectors[k]) begin
			@(negedge i_clock);
			run_vector(vectors[k], k);
		end
		// o_fault must hold while the checker keeps watching
		repeat (20) @(negedge i_clock);
		if (saw_invalid && !o_fault) begin
			tb_errors++;
			$display("o_fault is low at the end of the run");
		end
		if (checker_results != expected_results) begin
			tb_errors++;
			$display("checker compared %0d results, %0d were expected",
				checker_results, expected_results);
		end
		$display("errors: %0d from the checker, %0d from the testbench, %0d results compared",
			checker_errors, tb_errors, checker_results);
		if (checker_errors == 0 && tb_errors == 0) begin
			$display("Simulation finished: PASS");
		end else begin
			$display("Simulation finished: FAIL");
		end
		$finish;
	end

endmodule

//--- src.f
+incdir+logic
logic/exec_pkg.sv
logic/exec_alu.sv
logic/exec_multiply.sv
logic/exec_divide.sv
logic/exec_stage.sv
logic/exec_csr_file.sv
logic/exec_top.sv
verification/exec_checker.sv
verification/tb_exec.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the execute stage testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	-f src.f --top-module tb_exec -o tb_exec

output="$(./obj_dir/tb_exec)"
echo "$output"

if echo "$output" | grep -qx "Simulation finished: PASS"; then
	exit 0
else
	exit 1
fi

//--- verification/exec_vectors.txt
# class alu sel1 sel2 cop pc imm rs1 rs2 | expected: rd jump jump_pc mem_address
# all fields hex; class 8 is the invalid class and must stay the last line
0 0 1 2 0 00000000 00000000 7fffffff 00000001 80000000 0 00000000 00000000
0 1 1 2 0 00000000 00000000 00000003 00000005 fffffffe 0 00000000 00000000
0 2 1 2 0 00000000 00000000 f0f0f0f0 ff00ff00 f000f000 0 00000000 00000000
0 4 1 4 0 00000000 0000ff00 0f0f0f0f 00000000 0f0ff00f 0 00000000 00000000
1 5 1 2 0 00000000 00000000 00000001 0000001f 80000000 0 00000000 00000000
1 6 1 2 0 00000000 00000000 80000000 00000004 08000000 0 00000000 00000000
1 7 1 2 0 00000000 00000000 80000000 00000004 f8000000 0 00000000 00000000
2 a 1 2 0 00000000 00000000 ffffffff 00000001 00000001 0 00000000 00000000
2 c 1 2 0 00000000 00000000 ffffffff 00000001 00000000 0 00000000 00000000
3 0 3 4 0 00001000 00000020 00000000 00000000 00001004 1 00001020 00000000
3 0 1 4 0 00002000 00000005 00003000 00000000 00002004 1 00003004 00000000
4 8 1 2 0 00000100 fffffff0 00000005 00000005 00000000 1 000000f0 00000000
4 a 1 2 0 00000200 00000040 00000005 fffffffb 00000000 1 00000204 00000000
4 d 1 2 0 00000300 00000010 ffffffff 00000001 00000000 1 00000310 00000000
5 0 1 4 0 00000000 fffffffc 00001000 00000000 00000000 0 00000000 00000ffc
6 0 1 4 0 00000000 00000008 00002000 deadbeef deadbeef 0 00000000 00002008
7 0 1 2 0 00000000 00000000 fffffffe 00000003 fffffffa 0 00000000 00000000
7 0 1 2 1 00000000 00000000 80000000 80000000 40000000 0 00000000 00000000
7 0 1 2 2 00000000 00000000 ffffffff ffffffff fffffffe 0 00000000 00000000
7 0 1 2 3 00000000 00000000 fffffff9 00000002 fffffffd 0 00000000 00000000
7 0 1 2 5 00000000 00000000 fffffff9 00000002 ffffffff 0 00000000 00000000
7 0 1 2 4 00000000 00000000 00000064 00000007 0000000e 0 00000000 00000000
7 0 1 2 6 00000000 00000000 00000064 00000007 00000002 0 00000000 00000000
7 0 1 2 3 00000000 00000000 00000005 00000000 ffffffff 0 00000000 00000000
7 0 1 2 5 00000000 00000000 00000005 00000000 00000005 0 00000000 00000000
7 0 1 2 3 00000000 00000000 80000000 ffffffff 80000000 0 00000000 00000000
7 0 1 2 5 00000000 00000000 80000000 ffffffff 00000000 0 00000000 00000000
7 0 1 2 7 00000000 00000340 12345678 00000000 00000000 0 00000000 00000000
7 0 1 2 8 00000000 00000340 000000f0 00000000 12345678 0 00000000 00000000
7 0 1 2 8 00000000 00000340 00000000 00000000 123456f8 0 00000000 00000000
7 0 1 2 7 00000000 00000305 00000100 00000000 00000000 0 00000000 00000000
7 0 1 2 7 00000000 00000341 00002000 00000000 00000000 0 00000000 00000000
7 0 1 2 9 00000000 00000000 00000000 00000000 00000000 1 00000100 00000000
7 0 1 2 a 00000000 00000000 00000000 00000000 00000000 1 00002000 00000000
8 0 1 2 0 00000000 00000000 00000000 00000000 00000000 0 00000000 00000000
